/* dv/smc_lite_properties.sv */
`timescale 1ns/1ps
// External bus protocol checks sampled on hclk and disabled during reset
module smc_lite_properties (
  input logic       hclk,
  input logic       reset,
  input logic       smc_n_cs,
  input logic       smc_n_rd,
  input logic       smc_n_wr,
  input logic [3:0] smc_n_we,
  input logic       smc_n_ext_oe
);

  logic any_wr;  // Any write strobe low

  assign any_wr = !smc_n_wr || (smc_n_we != 4'hf);

  // ------------------------------------------------
  // Strobes only inside chip select
  // ------------------------------------------------
  cs_covers_strobe: assert property (@(posedge hclk) disable iff (reset)
    (!smc_n_rd || any_wr) |-> !smc_n_cs)
    else $error("strobe low with chip select high");

  // Read and write never overlap
  rd_wr_exclusive: assert property (@(posedge hclk) disable iff (reset)
    !(!smc_n_rd && any_wr))
    else $error("read and write strobes low together");

  // Write drivers off while reading
  oe_off_on_read: assert property (@(posedge hclk) disable iff (reset)
    !smc_n_rd |-> smc_n_ext_oe)
    else $error("output enable low during a read");

endmodule

bind smc_lite_top smc_lite_properties u_props (
  .hclk(hclk), .reset(reset), .smc_n_cs(smc_n_cs), .smc_n_rd(smc_n_rd),
  .smc_n_wr(smc_n_wr), .smc_n_we(smc_n_we), .smc_n_ext_oe(smc_n_ext_oe)
);

/* dv/smc_lite_tb.sv */
`timescale 1ns/1ps
// Default timing only and addresses kept inside the 64 word memory model
module smc_lite_tb;

  import smc_bus_pkg::*;

  localparam int unsigned CS_LEAD     = 1;
  localparam int unsigned WAIT_STATES = 2;
  localparam int unsigned CS_TRAIL    = 1;
  localparam int unsigned N_DIRECTED  = 8;
  localparam int unsigned N_RANDOM    = 300;
  localparam int unsigned CS_MIN      = CS_LEAD + WAIT_STATES + 1 + CS_TRAIL;
  localparam int unsigned ACCESS_MAX  = CS_MIN + 2;  // Plus start and push cycles
  localparam int unsigned TIMEOUT_CYC = (N_DIRECTED + N_RANDOM) * (ACCESS_MAX + 20);

  logic                  hclk = 1'b0;
  logic                  reset;
  logic                  req_valid, req_ready, rsp_valid, rsp_ready;
  smc_req_t              req;
  smc_rsp_t              rsp;
  logic [ADDR_WIDTH-1:0] smc_addr;
  logic [DATA_WIDTH-1:0] smc_data, data_smc;
  logic [3:0]            smc_n_be, smc_n_we;
  logic                  smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  logic [7:0]  ref_mem [0:255];  // Reference bytes
  smc_rsp_t    exp_q[$];         // Expected responses in order
  int unsigned n_sent = 0;
  int unsigned n_rcvd = 0;
  int unsigned cs_run = 0;       // Chip select low cycles
  int unsigned stb_run = 0;      // Strobe low cycles
  int unsigned stall_left = 0;   // Host stall cycles left
  logic        random_ready;

  always #4 hclk = ~hclk;  // 8 ns period

  smc_lite_top uut (
    .hclk(hclk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready), .req(req),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp), .smc_addr(smc_addr),
    .smc_data(smc_data), .data_smc(data_smc), .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs),
    .smc_n_wr(smc_n_wr), .smc_n_we(smc_n_we), .smc_n_rd(smc_n_rd),
    .smc_n_ext_oe(smc_n_ext_oe), .smc_busy(smc_busy)
  );

  smc_mem_model u_mem (
    .smc_addr(smc_addr), .smc_data(smc_data), .data_smc(data_smc),
    .smc_n_cs(smc_n_cs), .smc_n_rd(smc_n_rd), .smc_n_we(smc_n_we)
  );

  // ------------------------------------------------
  // Reporting
  // ------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR t=%0t %s got=%0h expected=%0h", $time, name, got, exp));
    end
  endtask

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic logic [31:0] ref_word(input logic [7:0] a);
    return {ref_mem[{a[7:2], 2'd3}], ref_mem[{a[7:2], 2'd2}],
            ref_mem[{a[7:2], 2'd1}], ref_mem[{a[7:2], 2'd0}]};
  endfunction

  // Lane rule applied at acceptance and expected response queued
  task automatic ref_apply(input smc_req_t r);
    logic [3:0] mask;
    smc_rsp_t   e;
    case (r.size)
      XFER_BYTE: mask = 4'b0001 << r.addr[1:0];
      XFER_HALF: mask = r.addr[1] ? 4'b1100 : 4'b0011;
      default:   mask = 4'b1111;
    endcase
    if (r.write) begin
      for (int l = 0; l < 4; l++) begin
        if (mask[l]) begin
          if (r.size == XFER_BYTE) ref_mem[{r.addr[7:2], 2'(l)}] = r.wdata[7:0];
          else if (r.size == XFER_HALF) ref_mem[{r.addr[7:2], 2'(l)}] = r.wdata[(l%2)*8 +: 8];
          else ref_mem[{r.addr[7:2], 2'(l)}] = r.wdata[l*8 +: 8];
        end
      end
      e.rdata = '0;  // Write acknowledge
    end else begin
      e.rdata = ref_word(r.addr[7:0]);
    end
    e.write = r.write;
    exp_q.push_back(e);
    n_sent++;
  endtask

  function automatic smc_req_t make_req(input logic [7:0] a, input logic w,
                                        input xfer_size_e s, input logic [31:0] d);
    smc_req_t r;
    r.addr  = {24'h0, a};
    r.write = w;
    r.size  = s;
    r.wdata = d;
    return r;
  endfunction

  // Hold valid and a stable payload until accepted
  task automatic send_req(input smc_req_t r);
    logic taken;
    req       = r;
    req_valid = 1'b1;
    do begin
      @(negedge hclk);
      taken = req_ready;
      if (taken) ref_apply(r);
      @(posedge hclk);
      #1;
    end while (!taken);
    req_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (n_rcvd != n_sent) @(posedge hclk);
    #1;
  endtask

  // ------------------------------------------------
  // Response side and pin monitor
  // ------------------------------------------------
  // Stall lengths long enough to fill the response buffer
  always @(negedge hclk) begin
    if (stall_left != 0) stall_left--;
    else if (random_ready && $urandom_range(0, 3) == 0) stall_left = $urandom_range(1, 12);
  end

  always @(posedge hclk) begin
    #1;
    rsp_ready = (stall_left == 0);
  end

  always @(negedge hclk) begin
    smc_rsp_t e;
    if (!reset && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) fail_run("a response arrived with no request outstanding");
      e = exp_q.pop_front();
      check_value("rsp.write", 64'(rsp.write), 64'(e.write));
      check_value("rsp.rdata", 64'(rsp.rdata), 64'(e.rdata));
      n_rcvd++;
    end
  end

  always @(negedge hclk) begin
    if (!reset) begin
      if (!smc_n_cs) cs_run++;
      else if (cs_run != 0) begin
        if (cs_run < CS_MIN) check_value("smc_n_cs low cycles", 64'(cs_run), 64'(CS_MIN));
        cs_run = 0;
      end
      if (!smc_n_rd || !smc_n_wr) stb_run++;
      else if (stb_run != 0) begin
        check_value("strobe low cycles", 64'(stb_run), 64'(WAIT_STATES + 1));
        stb_run = 0;
      end
    end
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYC) @(posedge hclk);
    fail_run("timeout: a response never arrived");
  end

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    smc_req_t r;
    void'($urandom(56));
    reset        = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    rsp_ready    = 1'b1;
    random_ready = 1'b0;
    for (int i = 0; i < 64; i++) begin
      {ref_mem[4*i+3], ref_mem[4*i+2], ref_mem[4*i+1], ref_mem[4*i]} =
        {8'hc3 ^ 8'(i), 8'(i), 8'h5a ^ 8'(i * 3), ~8'(i)};  // Same fill as the memory
    end
    repeat (2) @(posedge hclk);
    #1 reset = 1'b0;

    // Idle state after reset
    @(negedge hclk);
    check_value("smc_n_cs", 64'(smc_n_cs), 64'(1));
    check_value("smc_n_rd", 64'(smc_n_rd), 64'(1));
    check_value("smc_n_wr", 64'(smc_n_wr), 64'(1));
    check_value("smc_n_we", 64'(smc_n_we), 64'(4'hf));
    check_value("smc_n_ext_oe", 64'(smc_n_ext_oe), 64'(1));
    check_value("smc_n_be", 64'(smc_n_be), 64'(4'hf));
    check_value("rsp_valid", 64'(rsp_valid), 64'(0));
    check_value("req_ready", 64'(req_ready), 64'(1));
    check_value("smc_busy", 64'(smc_busy), 64'(0));
    @(posedge hclk);
    #1;

    // Word write and read back followed by partial lanes
    send_req(make_req(8'h40, 1'b1, XFER_WORD, 32'hdeadbeef));
    send_req(make_req(8'h40, 1'b0, XFER_WORD, 32'h0));
    send_req(make_req(8'h81, 1'b1, XFER_BYTE, 32'h11));
    send_req(make_req(8'h86, 1'b1, XFER_HALF, 32'h2233));
    send_req(make_req(8'h80, 1'b0, XFER_WORD, 32'h0));
    send_req(make_req(8'h84, 1'b0, XFER_WORD, 32'h0));
    send_req(make_req(8'h84, 1'b1, XFER_HALF, 32'h7788));
    send_req(make_req(8'h84, 1'b0, XFER_WORD, 32'h0));
    wait_drained();

    // Random mixed stream with back-pressure
    random_ready = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      r = make_req(8'($urandom), 1'($urandom), xfer_size_e'($urandom_range(0, 2)), $urandom);
      send_req(r);
      if ($urandom_range(0, 7) == 0) begin
        repeat ($urandom_range(1, 4)) @(posedge hclk);
        #1;
      end
    end
    wait_drained();
    repeat (20) @(posedge hclk);  // Catch late duplicates

    if (exp_q.size() != 0 || n_rcvd != N_DIRECTED + N_RANDOM) begin
      fail_run($sformatf("response count %0d does not match %0d requests", n_rcvd, n_sent));
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* dv/smc_mem_model.sv */
`timescale 1ns/1ps
// Behavioral SRAM of 64 words decoded from byte address bits 7:2 that drives zero when not read
module smc_mem_model (
  input  logic [smc_bus_pkg::ADDR_WIDTH-1:0] smc_addr,
  input  logic [smc_bus_pkg::DATA_WIDTH-1:0] smc_data,
  output logic [smc_bus_pkg::DATA_WIDTH-1:0] data_smc,
  input  logic                               smc_n_cs,
  input  logic                               smc_n_rd,
  input  logic [3:0]                         smc_n_we
);

  import smc_bus_pkg::*;

  logic [DATA_WIDTH-1:0] mem [0:63];
  logic [5:0]            idx;  // Word index

  assign idx = smc_addr[7:2];

  // ------------------------------------------------
  // Fill pattern from the whole word address
  // ------------------------------------------------
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = {8'hc3 ^ 8'(i), 8'(i), 8'h5a ^ 8'(i * 3), ~8'(i)};
    end
  end

  // Level sensitive write with lanes gated by their strobes
  always @(smc_n_cs or smc_n_we or idx or smc_data) begin
    if (!smc_n_cs) begin
      for (int l = 0; l < 4; l++) begin
        if (!smc_n_we[l]) mem[idx][l*8 +: 8] = smc_data[l*8 +: 8];
      end
    end
  end

  // Asynchronous read path
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[idx] : '0;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the smc_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f smc_lite.f --top-module smc_lite_tb -o smc_lite_sim; then
  echo "compile step failed"
  exit 1
fi

if ! ./obj_dir/smc_lite_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation returned a failing status"
  exit 1
fi

cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  exit 1
fi

exit 0

/* smc_lite.f */
src/smc_bus_pkg.sv
src/smc_timing_pkg.sv
src/smc_hold_reg.sv
src/smc_addr_gen.sv
src/smc_timing_fsm.sv
src/smc_strobe_gen.sv
src/smc_lite_top.sv
dv/smc_mem_model.sv
dv/smc_lite_properties.sv
dv/smc_lite_tb.sv

/* src/smc_addr_gen.sv */
`timescale 1ns/1ps
// Low justified write data is copied to every lane and byte enables hold until the next start
module smc_addr_gen (
  input  logic                               hclk,
  input  logic                               reset,
  input  logic                               start,     // Request popped
  input  smc_bus_pkg::smc_req_t              req,       // Head of the request buffer
  output logic [smc_bus_pkg::ADDR_WIDTH-1:0] smc_addr,
  output logic [3:0]                         smc_n_be,  // Active low
  output logic [smc_bus_pkg::DATA_WIDTH-1:0] smc_data,
  output logic                               wr_flag    // Current access is a write
);

  import smc_bus_pkg::*;

  logic [3:0]            n_be_d;   // Decoded lanes
  logic [DATA_WIDTH-1:0] wdata_d;  // Lane aligned write data

  // ------------------------------------------------
  // Lane decode
  // ------------------------------------------------
  always_comb begin
    case (req.size)
      XFER_BYTE: begin
        n_be_d  = ~(4'b0001 << req.addr[1:0]);  // One lane
        wdata_d = {4{req.wdata[7:0]}};
      end
      XFER_HALF: begin
        // Lanes 3:2 or 1:0 by address bit 1
        n_be_d  = req.addr[1] ? 4'b0011 : 4'b1100;
        wdata_d = {2{req.wdata[15:0]}};
      end
      default: begin
        n_be_d  = 4'b0000;  // Whole word
        wdata_d = req.wdata;
      end
    endcase
  end

  // ------------------------------------------------
  // Access registers
  // ------------------------------------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      smc_n_be <= 4'hf;  // No lane
      wr_flag  <= 1'b0;
    end else if (start) begin
      smc_n_be <= n_be_d;
      wr_flag  <= req.write;
    end
  end

  // Address and write data held for the whole access
  always_ff @(posedge hclk) begin
    if (start) begin
      smc_addr <= req.addr;
      smc_data <= wdata_d;
    end
  end

endmodule

/* src/smc_bus_pkg.sv */
// Host side types for a single 32-bit word bus with no error response
package smc_bus_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int unsigned DATA_WIDTH = 32;  // Host and external data, one word
  localparam int unsigned ADDR_WIDTH = 32;  // Byte address

  // Transfer size of one host access
  typedef enum logic [1:0] {
    XFER_BYTE = 2'b00,
    XFER_HALF = 2'b01,
    XFER_WORD = 2'b10   // 2'b11 is treated as a word too
  } xfer_size_e;

  // ------------------------------------------------
  // Host request and response
  // ------------------------------------------------
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;   // Byte address
    logic                  write;  // 1 for write
    xfer_size_e            size;
    logic [DATA_WIDTH-1:0] wdata;  // Low justified write data
  } smc_req_t;

  // Read data is the raw bus word
  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;  // Zero on a write acknowledge
    logic                  write;  // Kind of access that finished
  } smc_rsp_t;

endpackage

/* src/smc_hold_reg.sv */
`timescale 1ns/1ps
// One-entry valid/ready buffer that streams when popped and pushed in the same cycle
module smc_hold_reg #(
  parameter type payload_t = logic
) (
  input  logic     hclk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full_q;  // Entry holds a payload
  payload_t data_q;

  // Room when empty or being drained this cycle
  assign in_ready  = !full_q || out_ready;
  assign out_valid = full_q;
  assign out_data  = data_q;

  // Occupancy
  always_ff @(posedge hclk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (in_ready) begin
      full_q <= in_valid;  // New entry or drained
    end
  end

  // Payload stays stable until popped
  always_ff @(posedge hclk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule

/* src/smc_lite_top.sv */
`timescale 1ns/1ps
// One access at a time with the external bus as wide as the host word and no error response
module smc_lite_top #(
  parameter int unsigned CS_LEAD     = 1,  // Chip select lead cycles
  parameter int unsigned WAIT_STATES = 2,  // Strobe lasts WAIT_STATES+1
  parameter int unsigned CS_TRAIL    = 1   // Bus float cycles
) (
  input  logic                               hclk,
  input  logic                               reset,
  // Host request and response channels
  input  logic                               req_valid,
  output logic                               req_ready,
  input  smc_bus_pkg::smc_req_t              req,
  output logic                               rsp_valid,
  input  logic                               rsp_ready,
  output smc_bus_pkg::smc_rsp_t              rsp,
  // External memory bus
  output logic [smc_bus_pkg::ADDR_WIDTH-1:0] smc_addr,
  output logic [smc_bus_pkg::DATA_WIDTH-1:0] smc_data,
  input  logic [smc_bus_pkg::DATA_WIDTH-1:0] data_smc,
  output logic [3:0]                         smc_n_be,
  output logic                               smc_n_cs,
  output logic                               smc_n_wr,
  output logic [3:0]                         smc_n_we,
  output logic                               smc_n_rd,
  output logic                               smc_n_ext_oe,
  output logic                               smc_busy
);

  import smc_bus_pkg::*;
  import smc_timing_pkg::*;

  localparam smc_timing_t TIMING = '{
    lead:  LEAD_BITS'(CS_LEAD),
    ws:    WS_BITS'(WAIT_STATES),
    trail: LEAD_BITS'(CS_TRAIL)
  };

  smc_req_t req_q;         // Buffered request
  logic     req_q_valid;
  logic     start;         // Request popped into the sequencer
  smc_rsp_t rsp_d;
  logic     rsp_push;
  logic     rsp_in_ready;  // Response buffer has room
  phase_e   phase;
  logic     last;
  logic     wr_flag;

  // ------------------------------------------------
  // Request buffer and access registers
  // ------------------------------------------------
  smc_hold_reg #(.payload_t(smc_req_t)) u_req_buf (
    .hclk(hclk), .reset(reset),
    .in_valid(req_valid), .in_ready(req_ready), .in_data(req),
    .out_valid(req_q_valid), .out_ready(start), .out_data(req_q)
  );

  smc_addr_gen u_addr_gen (
    .hclk(hclk), .reset(reset), .start(start), .req(req_q),
    .smc_addr(smc_addr), .smc_n_be(smc_n_be), .smc_data(smc_data), .wr_flag(wr_flag)
  );

  // ------------------------------------------------
  // Sequencer, pins and response buffer
  // ------------------------------------------------
  smc_timing_fsm #(
    .CS_LEAD(int'(TIMING.lead)), .WAIT_STATES(int'(TIMING.ws)), .CS_TRAIL(int'(TIMING.trail))
  ) u_timing_fsm (
    .hclk(hclk), .reset(reset), .req_valid(req_q_valid), .start(start),
    .rsp_full(!rsp_in_ready), .phase(phase), .last(last), .busy(smc_busy)
  );

  smc_strobe_gen u_strobe_gen (
    .hclk(hclk), .reset(reset), .phase(phase), .last(last), .wr_flag(wr_flag),
    .n_be(smc_n_be), .data_smc(data_smc), .rsp_push(rsp_push), .rsp(rsp_d),
    .smc_n_cs(smc_n_cs), .smc_n_rd(smc_n_rd), .smc_n_wr(smc_n_wr),
    .smc_n_we(smc_n_we), .smc_n_ext_oe(smc_n_ext_oe)
  );

  smc_hold_reg #(.payload_t(smc_rsp_t)) u_rsp_buf (
    .hclk(hclk), .reset(reset),
    .in_valid(rsp_push), .in_ready(rsp_in_ready), .in_data(rsp_d),
    .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp)
  );

endmodule

/* src/smc_strobe_gen.sv */
`timescale 1ns/1ps
// Pins follow the sequencer phase by one cycle and a read returns the raw bus word
module smc_strobe_gen (
  input  logic                               hclk,
  input  logic                               reset,
  input  smc_timing_pkg::phase_e             phase,     // Sequencer phase
  input  logic                               last,      // Sequencer final cycle
  input  logic                               wr_flag,
  input  logic [3:0]                         n_be,      // Active low lanes
  input  logic [smc_bus_pkg::DATA_WIDTH-1:0] data_smc,  // External read data
  output logic                               rsp_push,
  output smc_bus_pkg::smc_rsp_t              rsp,
  output logic                               smc_n_cs,
  output logic                               smc_n_rd,
  output logic                               smc_n_wr,
  output logic [3:0]                         smc_n_we,
  output logic                               smc_n_ext_oe
);

  import smc_bus_pkg::*;
  import smc_timing_pkg::*;

  logic                  in_strobe;  // Sequencer in strobe phase
  logic                  rd_sample;  // Final read strobe cycle on the pins
  logic [DATA_WIDTH-1:0] rd_q;       // Captured read word

  assign in_strobe = (phase == PH_STROBE);

  // ------------------------------------------------
  // External pins
  // ------------------------------------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= 4'hf;
      smc_n_ext_oe <= 1'b1;
    end else begin
      smc_n_cs     <= (phase == PH_IDLE);  // Low through lead, strobe and trail
      smc_n_rd     <= !(in_strobe && !wr_flag);
      smc_n_wr     <= !(in_strobe && wr_flag);
      smc_n_we     <= (in_strobe && wr_flag) ? n_be : 4'hf;  // Only enabled lanes
      // Drivers on from lead through strobe, off for the trail
      smc_n_ext_oe <= !(wr_flag && ((phase == PH_LEAD) || in_strobe));
    end
  end

  // ------------------------------------------------
  // Response
  // ------------------------------------------------
  // Pins still in strobe while the sequencer has moved on
  assign rd_sample = !smc_n_rd && !in_strobe;

  always_ff @(posedge hclk) begin
    if (rd_sample) begin
      rd_q <= data_smc;
    end
  end

  // Push lines up with the final cycle on the pins
  always_ff @(posedge hclk) begin
    if (reset) begin
      rsp_push <= 1'b0;
    end else begin
      rsp_push <= last;
    end
  end

  assign rsp.write = wr_flag;
  // Live bus data when the push falls in the final strobe cycle
  assign rsp.rdata = wr_flag ? '0 : (rd_sample ? data_smc : rd_q);

endmodule

/* src/smc_timing_fsm.sv */
`timescale 1ns/1ps
// Counts wrap at the counter widths so CS_LEAD and CS_TRAIL stay below 4 and WAIT_STATES below 256
module smc_timing_fsm #(
  parameter int unsigned CS_LEAD     = 1,
  parameter int unsigned WAIT_STATES = 2,
  parameter int unsigned CS_TRAIL    = 1
) (
  input  logic                   hclk,
  input  logic                   reset,
  input  logic                   req_valid,  // Request waiting
  output logic                   start,      // Pop of the request buffer
  input  logic                   rsp_full,   // Response buffer cannot take a push
  output smc_timing_pkg::phase_e phase,      // Phase the pins take next cycle
  output logic                   last,       // Final cycle of the access
  output logic                   busy
);

  import smc_timing_pkg::*;

  localparam smc_timing_t CFG = '{
    lead:  LEAD_BITS'(CS_LEAD),
    ws:    WS_BITS'(WAIT_STATES),
    trail: LEAD_BITS'(CS_TRAIL)
  };

  phase_e               state_q;
  phase_e               state_d;
  logic                 hold_q;     // Trail held for a full response buffer
  logic                 hold_d;
  logic [LEAD_BITS-1:0] lead_cnt;   // Lead cycles left
  logic [WS_BITS-1:0]   ws_cnt;     // Wait states left
  logic [LEAD_BITS-1:0] trail_cnt;  // Trail cycles left

  assign start = (state_q == PH_IDLE) && req_valid;
  assign phase = hold_q ? PH_IDLE : state_q;  // Held trail releases chip select
  assign busy  = (state_q != PH_IDLE);

  // ------------------------------------------------
  // Next phase
  // ------------------------------------------------
  always_comb begin
    state_d = state_q;
    hold_d  = 1'b0;
    last    = 1'b0;
    case (state_q)
      PH_IDLE: begin
        if (start) begin
          state_d = (CFG.lead != '0) ? PH_LEAD : PH_STROBE;  // Skip empty lead
        end
      end
      PH_LEAD: begin
        if (lead_cnt <= LEAD_BITS'(1)) state_d = PH_STROBE;
      end
      PH_STROBE: begin
        if (ws_cnt == '0) begin
          if (CFG.trail != '0) begin
            state_d = PH_TRAIL;
          end else if (rsp_full) begin
            state_d = PH_TRAIL;  // No trail but must wait
            hold_d  = 1'b1;
          end else begin
            last    = 1'b1;
            state_d = PH_IDLE;
          end
        end
      end
      default: begin  // Trail
        if (trail_cnt <= LEAD_BITS'(1)) begin
          if (rsp_full) begin
            hold_d = 1'b1;  // Extend until a push fits
          end else begin
            last    = 1'b1;
            state_d = PH_IDLE;
          end
        end
      end
    endcase
  end

  // ------------------------------------------------
  // State and counters
  // ------------------------------------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      state_q   <= PH_IDLE;
      hold_q    <= 1'b0;
      lead_cnt  <= '0;
      ws_cnt    <= '0;
      trail_cnt <= '0;
    end else begin
      state_q <= state_d;
      hold_q  <= hold_d;
      if (start) begin
        lead_cnt  <= CFG.lead;  // Load all counts at once
        ws_cnt    <= CFG.ws;
        trail_cnt <= CFG.trail;
      end else begin
        case (state_q)
          PH_LEAD:   if (lead_cnt > LEAD_BITS'(1)) lead_cnt <= lead_cnt - 1'b1;
          PH_STROBE: if (ws_cnt != '0) ws_cnt <= ws_cnt - 1'b1;
          PH_TRAIL:  if (trail_cnt > LEAD_BITS'(1)) trail_cnt <= trail_cnt - 1'b1;
          default:   ;
        endcase
      end
    end
  end

endmodule

/* src/smc_timing_pkg.sv */
// Access phases and timing counts for the external bus sequencer with lead and trail up to 3
package smc_timing_pkg;

  // ------------------------------------------------
  // Count widths
  // ------------------------------------------------
  localparam int unsigned LEAD_BITS = 2;  // Lead and trail counters
  localparam int unsigned WS_BITS   = 8;  // Wait state counter

  // Phase of one access on the external bus
  typedef enum logic [1:0] {
    PH_IDLE   = 2'b00,  // Chip select high
    PH_LEAD   = 2'b01,  // Chip select low before the strobe
    PH_STROBE = 2'b10,  // Read or write strobe low
    PH_TRAIL  = 2'b11   // Bus float time
  } phase_e;

  // Cycle counts of one access
  typedef struct packed {
    logic [LEAD_BITS-1:0] lead;   // Lead cycles, 0 skips the phase
    logic [WS_BITS-1:0]   ws;     // Wait states, strobe lasts ws+1
    logic [LEAD_BITS-1:0] trail;  // Trail cycles, 0 skips the phase
  } smc_timing_t;

endpackage
